// File: src/fetch_pkg.sv
package fetch_pkg;

    // ####################################################################
    // address and cache geometry
    // ####################################################################

    localparam int addr_w = 32;
    localparam int word_w = 32;

    localparam int line_words = 4;
    localparam int num_lines = 16;

    // byte offset inside a word, then word select inside a line.
    localparam int offset_bits = 2;
    localparam int word_sel_bits = $clog2(line_words);
    localparam int index_bits = $clog2(num_lines);
    localparam int tag_bits = addr_w - offset_bits - word_sel_bits - index_bits;

    localparam logic [addr_w-1:0] reset_pc = '0;

    // ####################################################################
    // stream payloads
    // ####################################################################

    typedef struct packed {
        logic [addr_w-1:0] addr;
    } fetch_req_t;

    // err marks a word that came back with an APB slave error.
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [word_w-1:0] data;
        logic              err;
    } fetch_rsp_t;

endpackage

// File: src/fetch_pc_gen.sv
`timescale 1ns/1ps

module fetch_pc_gen (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           redirect_valid,
    input  logic [fetch_pkg::addr_w-1:0]   redirect_addr,
    output logic                           req_valid,
    input  logic                           req_ready,
    output fetch_pkg::fetch_req_t          req
);

    logic [fetch_pkg::addr_w-1:0] pc_q;
    logic                         active_q;

    // the target goes out on the cycle after the redirect.
    assign req_valid = active_q && !redirect_valid;
    assign req.addr = pc_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc_q <= fetch_pkg::reset_pc;
            active_q <= 1'b0;
        end
        else
        begin
            active_q <= 1'b1;
            if (redirect_valid)
            begin
                pc_q <= redirect_addr;
            end
            else if (req_valid && req_ready)
            begin
                pc_q <= pc_q + fetch_pkg::addr_w'(4);
            end
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> $stable(req));

endmodule

// File: src/pipe_slice.sv
`timescale 1ns/1ps

module pipe_slice #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full_q;
    payload_t data_q;

    // takes a new item when empty or when the held one leaves this cycle.
    assign in_ready = !full_q || out_ready;
    assign out_valid = full_q;
    assign out_data = data_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            full_q <= 1'b0;
        end
        else if (flush)
        begin
            full_q <= 1'b0;
        end
        else if (in_valid && in_ready)
        begin
            full_q <= 1'b1;
        end
        else if (out_ready)
        begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
        begin
            data_q <= in_data;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready && !flush |=> out_valid && $stable(out_data));

endmodule

// File: src/icache_apb_refill.sv
`timescale 1ns/1ps

module icache_apb_refill (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cmd_valid,
    input  logic [fetch_pkg::addr_w-1:0]   cmd_addr,
    output logic                           done,
    output logic [fetch_pkg::word_w-1:0]   rdata,
    output logic                           err,
    output logic [fetch_pkg::addr_w-1:0]   paddr,
    output logic                           psel,
    output logic                           penable,
    output logic                           pwrite,
    input  logic [fetch_pkg::word_w-1:0]   prdata,
    input  logic                           pready,
    input  logic                           pslverr
);

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_access
    } state_t;

    state_t                       state_q;
    logic [fetch_pkg::addr_w-1:0] paddr_q;

    assign psel = (state_q != st_idle);
    assign penable = (state_q == st_access);
    assign pwrite = 1'b0;
    assign paddr = paddr_q;

    // completion is the single cycle where the slave accepts the access phase.
    assign done = (state_q == st_access) && pready;
    assign rdata = prdata;
    assign err = pslverr;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= st_idle;
        end
        else
        begin
            case (state_q)
                st_idle: state_q <= cmd_valid ? st_setup : st_idle;
                st_setup: state_q <= st_access;
                st_access: state_q <= pready ? st_idle : st_access;
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state_q == st_idle && cmd_valid)
        begin
            paddr_q <= cmd_addr;
        end
    end

    // the access phase always follows a setup phase of the same transfer.
    a_setup_first: assert property (@(posedge clk) disable iff (rst)
        $rose(penable) |-> psel && $past(psel) && $stable(paddr));

endmodule

// File: src/icache_lookup.sv
`timescale 1ns/1ps

module icache_lookup (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           flush,
    input  logic                           req_valid,
    output logic                           req_ready,
    input  fetch_pkg::fetch_req_t          req,
    output logic                           rsp_valid,
    input  logic                           rsp_ready,
    output fetch_pkg::fetch_rsp_t          rsp,
    output logic                           refill_req_valid,
    output logic [fetch_pkg::addr_w-1:0]   refill_addr,
    input  logic                           refill_done,
    input  logic [fetch_pkg::word_w-1:0]   refill_data,
    input  logic                           refill_err
);

    typedef enum logic [1:0] {
        st_lookup,
        st_refill,
        st_respond
    } state_t;

    state_t state_q;

    // ####################################################################
    // arrays
    // ####################################################################

    logic [fetch_pkg::num_lines-1:0] valid_q;
    logic [fetch_pkg::tag_bits-1:0]  tag_mem [fetch_pkg::num_lines];
    logic [fetch_pkg::word_w-1:0]    data_mem [fetch_pkg::num_lines][fetch_pkg::line_words];

    logic [fetch_pkg::tag_bits-1:0]      req_tag;
    logic [fetch_pkg::index_bits-1:0]    req_idx;
    logic [fetch_pkg::word_sel_bits-1:0] req_word;
    logic                                hit;

    assign req_tag = req.addr[fetch_pkg::addr_w-1 -: fetch_pkg::tag_bits];
    assign req_idx = req.addr[fetch_pkg::offset_bits+fetch_pkg::word_sel_bits +:
                              fetch_pkg::index_bits];
    assign req_word = req.addr[fetch_pkg::offset_bits +: fetch_pkg::word_sel_bits];
    assign hit = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);

    // ####################################################################
    // handshakes
    // ####################################################################

    fetch_pkg::fetch_req_t               miss_q;
    logic [fetch_pkg::word_sel_bits-1:0] beat_q;
    logic                                outstanding_q;
    logic                                drain_q;
    logic [fetch_pkg::word_w-1:0]        hold_data_q;
    logic                                hold_err_q;
    logic                                rsp_valid_q;
    fetch_pkg::fetch_rsp_t               rsp_q;
    logic                                rsp_free;
    logic                                accept;
    logic                                beat_ok;

    logic [fetch_pkg::index_bits-1:0]    miss_idx;
    logic [fetch_pkg::word_sel_bits-1:0] miss_word;

    assign miss_idx = miss_q.addr[fetch_pkg::offset_bits+fetch_pkg::word_sel_bits +:
                                  fetch_pkg::index_bits];
    assign miss_word = miss_q.addr[fetch_pkg::offset_bits +: fetch_pkg::word_sel_bits];

    assign rsp_free = !rsp_valid_q || rsp_ready;
    assign req_ready = (state_q == st_lookup) && rsp_free && !flush;
    assign accept = req_valid && req_ready;
    assign rsp_valid = rsp_valid_q;
    assign rsp = rsp_q;

    // a beat only counts if it belongs to the refill that is still wanted.
    assign beat_ok = refill_done && !drain_q && (state_q == st_refill);

    // only one APB read is ever in flight.
    assign refill_req_valid = (state_q == st_refill) && !outstanding_q && !flush;
    assign refill_addr = {miss_q.addr[fetch_pkg::addr_w-1:fetch_pkg::offset_bits+
                                      fetch_pkg::word_sel_bits],
                          beat_q, {fetch_pkg::offset_bits{1'b0}}};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= st_lookup;
            valid_q <= '0;
            rsp_valid_q <= 1'b0;
            outstanding_q <= 1'b0;
            drain_q <= 1'b0;
            beat_q <= '0;
        end
        else
        begin
            if (refill_req_valid)
            begin
                outstanding_q <= 1'b1;
            end
            else if (refill_done)
            begin
                outstanding_q <= 1'b0;
                drain_q <= 1'b0;
            end

            if (flush)
            begin
                state_q <= st_lookup;
                rsp_valid_q <= 1'b0;
                if (outstanding_q && !refill_done)
                begin
                    drain_q <= 1'b1;
                end
            end
            else
            begin
                if (rsp_ready)
                begin
                    rsp_valid_q <= 1'b0;
                end
                case (state_q)
                    st_lookup:
                    begin
                        if (accept && hit)
                        begin
                            rsp_valid_q <= 1'b1;
                        end
                        else if (accept)
                        begin
                            // the line is rewritten word by word, so it drops out now.
                            valid_q[req_idx] <= 1'b0;
                            beat_q <= '0;
                            state_q <= st_refill;
                        end
                    end
                    st_refill:
                    begin
                        if (beat_ok && refill_err)
                        begin
                            state_q <= st_respond;
                        end
                        else if (beat_ok)
                        begin
                            beat_q <= beat_q + 1'b1;
                            if (beat_q == fetch_pkg::word_sel_bits'(fetch_pkg::line_words - 1))
                            begin
                                valid_q[miss_idx] <= 1'b1;
                                state_q <= st_respond;
                            end
                        end
                    end
                    default:
                    begin
                        if (rsp_free)
                        begin
                            rsp_valid_q <= 1'b1;
                            state_q <= st_lookup;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            miss_q <= req;
            rsp_q <= '{addr: req.addr, data: data_mem[req_idx][req_word], err: 1'b0};
        end
        if (state_q == st_respond && rsp_free)
        begin
            rsp_q <= '{addr: miss_q.addr, data: hold_data_q, err: hold_err_q};
        end
        if (beat_ok)
        begin
            if (!refill_err)
            begin
                data_mem[miss_idx][beat_q] <= refill_data;
                tag_mem[miss_idx] <= miss_q.addr[fetch_pkg::addr_w-1 -: fetch_pkg::tag_bits];
            end
            if (refill_err || beat_q == miss_word)
            begin
                hold_data_q <= refill_data;
            end
            hold_err_q <= refill_err;
        end
    end

    a_one_refill: assert property (@(posedge clk) disable iff (rst)
        refill_req_valid |=> (!refill_req_valid until refill_done));

endmodule

// File: src/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           redirect_valid,
    input  logic [fetch_pkg::addr_w-1:0]   redirect_addr,
    output logic                           instr_valid,
    input  logic                           instr_ready,
    output fetch_pkg::fetch_rsp_t          instr,
    output logic [fetch_pkg::addr_w-1:0]   paddr,
    output logic                           psel,
    output logic                           penable,
    output logic                           pwrite,
    input  logic [fetch_pkg::word_w-1:0]   prdata,
    input  logic                           pready,
    input  logic                           pslverr
);

    logic                         pc_valid;
    logic                         pc_ready;
    fetch_pkg::fetch_req_t        pc_req;
    logic                         lk_valid;
    logic                         lk_ready;
    fetch_pkg::fetch_req_t        lk_req;
    logic                         rsp_valid;
    logic                         rsp_ready;
    fetch_pkg::fetch_rsp_t        rsp;
    logic                         refill_req_valid;
    logic [fetch_pkg::addr_w-1:0] refill_addr;
    logic                         refill_done;
    logic [fetch_pkg::word_w-1:0] refill_data;
    logic                         refill_err;

    fetch_pc_gen pc_gen_i (
        .clk(clk), .rst(rst),
        .redirect_valid(redirect_valid), .redirect_addr(redirect_addr),
        .req_valid(pc_valid), .req_ready(pc_ready), .req(pc_req)
    );

    pipe_slice #(.payload_t(fetch_pkg::fetch_req_t)) req_slice_i (
        .clk(clk), .rst(rst), .flush(redirect_valid),
        .in_valid(pc_valid), .in_ready(pc_ready), .in_data(pc_req),
        .out_valid(lk_valid), .out_ready(lk_ready), .out_data(lk_req)
    );

    icache_lookup lookup_i (
        .clk(clk), .rst(rst), .flush(redirect_valid),
        .req_valid(lk_valid), .req_ready(lk_ready), .req(lk_req),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp),
        .refill_req_valid(refill_req_valid), .refill_addr(refill_addr),
        .refill_done(refill_done), .refill_data(refill_data), .refill_err(refill_err)
    );

    icache_apb_refill apb_i (
        .clk(clk), .rst(rst),
        .cmd_valid(refill_req_valid), .cmd_addr(refill_addr),
        .done(refill_done), .rdata(refill_data), .err(refill_err),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    pipe_slice #(.payload_t(fetch_pkg::fetch_rsp_t)) rsp_slice_i (
        .clk(clk), .rst(rst), .flush(redirect_valid),
        .in_valid(rsp_valid), .in_ready(rsp_ready), .in_data(rsp),
        .out_valid(instr_valid), .out_ready(instr_ready), .out_data(instr)
    );

endmodule

// File: dv/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           redirect_valid,
    input  logic [fetch_pkg::addr_w-1:0]   redirect_addr,
    input  logic                           instr_valid,
    input  logic                           instr_ready,
    input  fetch_pkg::fetch_rsp_t          instr,
    input  logic [fetch_pkg::addr_w-1:0]   paddr,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic                           pready,
    input  logic                           pslverr
);

    int errors;
    int instr_count;
    int refill_count;

    logic [31:0] exp_addr;
    logic        discard;
    int          seq_beat;
    logic [27:0] seq_line;
    logic        err_pend;
    logic [27:0] err_line;
    logic [15:0] model_valid;
    logic [23:0] model_tag [16];

    task automatic report(input string msg);
        errors++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    // ####################################################################
    // instruction stream
    // ####################################################################

    task automatic check_instr();
        logic exp_err;
        exp_err = err_pend && (instr.addr[31:4] == err_line);
        instr_count++;
        if (instr.addr != exp_addr)
            report($sformatf("address %h, expected %h", instr.addr, exp_addr));
        if (instr.err != exp_err)
            report($sformatf("error flag %b at %h, expected %b", instr.err, instr.addr, exp_err));
        // an error response carries the failing beat, so its data is not compared.
        if (!exp_err && instr.data != (instr.addr ^ 32'hc0de0000))
            report($sformatf("data %h at %h", instr.data, instr.addr));
        if (exp_err)
            err_pend = 1'b0;
        exp_addr = exp_addr + 32'd4;
    endtask

    // ####################################################################
    // refill model
    // ####################################################################

    task automatic check_beat();
        if (discard || redirect_valid)
        begin
            discard = 1'b0;
            return;
        end
        if (seq_beat == 0)
        begin
            refill_count++;
            if (paddr[3:0] != 4'h0)
                report($sformatf("refill starts at %h, not a line base", paddr));
            if (model_valid[paddr[7:4]] && model_tag[paddr[7:4]] == paddr[31:8])
                report($sformatf("refill of resident line %h", paddr));
            model_valid[paddr[7:4]] = 1'b0;
            seq_line = paddr[31:4];
            if (err_pend && err_line == seq_line)
                err_pend = 1'b0;
        end
        else if (paddr != {seq_line, seq_beat[1:0], 2'b00})
        begin
            report($sformatf("refill read %h, expected %h", paddr,
                             {seq_line, seq_beat[1:0], 2'b00}));
        end
        if (pslverr)
        begin
            err_pend = 1'b1;
            err_line = seq_line;
            seq_beat = 0;
        end
        else if (seq_beat == 3)
        begin
            model_valid[seq_line[3:0]] = 1'b1;
            model_tag[seq_line[3:0]] = seq_line[27:4];
            seq_beat = 0;
        end
        else
        begin
            seq_beat++;
        end
    endtask

    // the lines just past the stream may hold a flushed miss, which the DUT invalidated.
    task automatic take_redirect();
        if (psel && !(penable && pready))
            discard = 1'b1;
        seq_beat = 0;
        for (int i = 0; i < 4; i++)
            model_valid[(exp_addr + 32'(4 * i)) >> 4 & 32'hf] = 1'b0;
        exp_addr = redirect_addr;
    endtask

    always @(posedge clk)
    begin
        if (rst)
        begin
            exp_addr = fetch_pkg::reset_pc;
            discard = 1'b0;
            seq_beat = 0;
            err_pend = 1'b0;
            model_valid = '0;
        end
        else
        begin
            if (pwrite !== 1'b0)
                report($sformatf("pwrite %b, expected 0", pwrite));
            if (instr_valid && instr_ready)
                check_instr();
            if (psel && penable && pready)
                check_beat();
            if (redirect_valid)
                take_redirect();
        end
    end

endmodule

// File: dv/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    localparam int max_steps = 16;
    localparam int reset_words = 8;

    logic                         clk;
    logic                         rst;
    logic                         redirect_valid;
    logic [fetch_pkg::addr_w-1:0] redirect_addr;
    logic                         instr_valid;
    logic                         instr_ready;
    fetch_pkg::fetch_rsp_t        instr;
    logic [fetch_pkg::addr_w-1:0] paddr;
    logic                         psel;
    logic                         penable;
    logic                         pwrite;
    logic [fetch_pkg::word_w-1:0] prdata;
    logic                         pready;
    logic                         pslverr;

    logic [31:0] pat [0:4*max_steps-1];
    logic [31:0] waits;
    logic [31:0] err_addr;
    logic [31:0] lfsr;
    int          wait_cnt;
    int          total;
    int          tb_errors;

    fetch_top fetch_top_i (.*);

    fetch_checker checker_i (
        .clk(clk), .rst(rst),
        .redirect_valid(redirect_valid), .redirect_addr(redirect_addr),
        .instr_valid(instr_valid), .instr_ready(instr_ready), .instr(instr),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pready(pready), .pslverr(pslverr)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic consume_words(input int count);
        int   taken;
        logic ready_bit;
        taken = 0;
        while (taken < count)
        begin
            @(negedge clk);
            // two LFSR bits give the consumer a ready rate of about three in four.
            lfsr = lfsr_step(lfsr);
            ready_bit = lfsr[0];
            lfsr = lfsr_step(lfsr);
            instr_ready = ready_bit | lfsr[0];
            if (instr_valid && instr_ready)
                taken++;
        end
    endtask

    // ####################################################################
    // APB memory
    // ####################################################################

    assign prdata = paddr ^ 32'hc0de0000;
    assign pslverr = psel && (err_addr != 0) && (paddr == err_addr);

    always @(negedge clk)
    begin
        if (psel && penable)
        begin
            if (wait_cnt >= waits)
                pready = 1'b1;
            else
            begin
                pready = 1'b0;
                wait_cnt++;
            end
        end
        else
        begin
            pready = 1'b0;
            wait_cnt = 0;
        end
    end

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        redirect_valid = 1'b0;
        redirect_addr = '0;
        instr_ready = 1'b0;
        pready = 1'b0;
        waits = 0;
        err_addr = 0;
        wait_cnt = 0;
        lfsr = 32'h808e;
        total = reset_words;
        tb_errors = 0;
        for (int i = 0; i < 4 * max_steps; i++)
            pat[i] = '0;
        $readmemh("dv/fetch_patterns.txt", pat);
        for (int i = 0; i < max_steps; i++)
            total += pat[4*i+1];

        fork
            begin
                repeat (total * 64 + 1000) @(posedge clk);
                $display("timeout: the instruction stream stalled");
                $display("Some tests failed");
                $finish;
            end
        join_none

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // the first words come from the reset address, before any redirect.
        consume_words(reset_words);

        for (int s = 0; s < max_steps && pat[4*s+1] != 0; s++)
        begin
            @(negedge clk);
            instr_ready = 1'b0;
            redirect_valid = 1'b1;
            redirect_addr = pat[4*s];
            waits = pat[4*s+2];
            err_addr = pat[4*s+3];
            @(negedge clk);
            redirect_valid = 1'b0;
            consume_words(pat[4*s+1]);
        end
        @(negedge clk);
        instr_ready = 1'b0;
        repeat (5) @(negedge clk);

        if (checker_i.refill_count == 0)
        begin
            tb_errors++;
            $display("no line refill was seen on the APB bus");
        end
        $display("errors %0d, tb errors %0d, instructions %0d, refills %0d",
                 checker_i.errors, tb_errors, checker_i.instr_count, checker_i.refill_count);
        if (checker_i.errors == 0 && tb_errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// File: filelist.f
src/fetch_pkg.sv
src/fetch_pc_gen.sv
src/pipe_slice.sv
src/icache_apb_refill.sv
src/icache_lookup.sv
src/fetch_top.sv
dv/fetch_checker.sv
dv/fetch_tb.sv

// File: dv/fetch_patterns.txt
// columns: redirect target, words to consume, APB wait states, error address (0 is none)
// all values hex
00000100 00000014 00000000 00000000
00000100 0000000c 00000001 00000000
00001100 00000008 00000002 00000000
00000100 00000008 00000000 00000000
00002048 00000004 00000003 00002048
00002040 00000008 00000001 00000000
00003000 00000028 00000000 00000000
00003010 00000006 00000002 00000000
00000ff0 0000000c 00000001 00000000
